// File: score_pkg.sv
`default_nettype none

package score_pkg;

    localparam int LCD_DATA_W = 8;
    localparam int SEG_W      = 7;
    localparam int DIGIT_W    = 3;
    localparam int SCAN_POS   = 8;

    typedef enum logic [2:0] {
        STEP_POWER_WAIT = 3'd0,
        STEP_FUNC_SET   = 3'd1,
        STEP_ENTRY_MODE = 3'd2,
        STEP_DISP_ON    = 3'd3,
        STEP_LINE1      = 3'd4,
        STEP_LINE2      = 3'd5,
        STEP_HOME_HOLD  = 3'd6,
        STEP_CLEAR      = 3'd7
    } lcd_step_e;

    // Code 3 is treated like WIN_NONE
    typedef enum logic [1:0] {
        WIN_NONE = 2'd0,
        WIN_P1   = 2'd1,
        WIN_P2   = 2'd2
    } winner_e;

    localparam logic [LCD_DATA_W-1:0] CMD_FUNC_SET   = 8'h3C; // 8-bit bus, 2 lines
    localparam logic [LCD_DATA_W-1:0] CMD_ENTRY_MODE = 8'h06;
    localparam logic [LCD_DATA_W-1:0] CMD_DISP_ON    = 8'h0C; // Display on, no cursor
    localparam logic [LCD_DATA_W-1:0] CMD_HOME       = 8'h02;
    localparam logic [LCD_DATA_W-1:0] CMD_CLEAR      = 8'h01;
    localparam logic [LCD_DATA_W-1:0] CMD_LINE1_ADDR = 8'h80;
    localparam logic [LCD_DATA_W-1:0] CMD_LINE2_ADDR = 8'hC0;

    localparam logic [LCD_DATA_W-1:0] CH_SPACE = 8'h20;
    localparam logic [LCD_DATA_W-1:0] CH_P     = 8'h50;
    localparam logic [LCD_DATA_W-1:0] CH_1     = 8'h31;
    localparam logic [LCD_DATA_W-1:0] CH_2     = 8'h32;
    localparam logic [LCD_DATA_W-1:0] CH_W     = 8'h51; // Shows as W on this panel
    localparam logic [LCD_DATA_W-1:0] CH_I     = 8'h69;
    localparam logic [LCD_DATA_W-1:0] CH_N     = 8'h6E;
    localparam logic [LCD_DATA_W-1:0] CH_HEART = 8'h9D; // Custom ROM glyph

    // Active low, index is the player value
    localparam logic [SEG_W-1:0] SEG_DIGIT [0:(1 << DIGIT_W)-1] = '{
        7'b1111111,
        7'b1001111,
        7'b0010010,
        7'b0000110,
        7'b1001100,
        7'b0100100,
        7'b1111111,
        7'b1111111
    };

    localparam logic [SEG_W-1:0] SEG_FILL = 7'b0000001; // Middle digits

endpackage

`default_nettype wire

// File: lcd_text_rom.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_text_rom (
    input  score_pkg::lcd_step_e                step,
    input  logic [7:0]                          pos,
    input  logic [1:0]                          winner,
    output logic                                rom_rs,
    output logic [score_pkg::LCD_DATA_W-1:0]    rom_byte
);

    score_pkg::winner_e                   win;
    logic                                 has_winner;
    logic [score_pkg::LCD_DATA_W-1:0]     digit_char;
    logic [score_pkg::LCD_DATA_W-1:0]     line1_char;
    logic [score_pkg::LCD_DATA_W-1:0]     line2_char;

    assign win = score_pkg::winner_e'(winner);

    always_comb begin
        case (win)
            score_pkg::WIN_P1: begin
                has_winner = 1'b1;
                digit_char = score_pkg::CH_1;
            end
            score_pkg::WIN_P2: begin
                has_winner = 1'b1;
                digit_char = score_pkg::CH_2;
            end
            default: begin // None, or the unused code 3
                has_winner = 1'b0;
                digit_char = score_pkg::CH_SPACE;
            end
        endcase
    end

    // " Px Win  " from position 1
    always_comb begin
        case (pos)
            8'd2:    line1_char = score_pkg::CH_P;
            8'd3:    line1_char = digit_char;
            8'd5:    line1_char = score_pkg::CH_W;
            8'd6:    line1_char = score_pkg::CH_I;
            8'd7:    line1_char = score_pkg::CH_N;
            default: line1_char = score_pkg::CH_SPACE;
        endcase
    end

    // Two groups of three hearts
    always_comb begin
        case (pos)
            8'd2, 8'd3, 8'd4,
            8'd6, 8'd7, 8'd8: line2_char = score_pkg::CH_HEART;
            default:          line2_char = score_pkg::CH_SPACE;
        endcase
    end

    always_comb begin
        rom_rs   = 1'b0;
        rom_byte = score_pkg::CH_SPACE;
        case (step)
            score_pkg::STEP_POWER_WAIT: begin
                rom_rs   = 1'b1; // Idle bus value
                rom_byte = '0;
            end
            score_pkg::STEP_FUNC_SET:   rom_byte = score_pkg::CMD_FUNC_SET;
            score_pkg::STEP_ENTRY_MODE: rom_byte = score_pkg::CMD_ENTRY_MODE;
            score_pkg::STEP_DISP_ON:    rom_byte = score_pkg::CMD_DISP_ON;
            score_pkg::STEP_LINE1: begin
                if (pos == 8'd0) begin
                    rom_byte = score_pkg::CMD_LINE1_ADDR;
                end else begin
                    rom_rs   = 1'b1;
                    rom_byte = has_winner ? line1_char : score_pkg::CH_SPACE;
                end
            end
            score_pkg::STEP_LINE2: begin
                if (pos == 8'd0) begin
                    rom_byte = score_pkg::CMD_LINE2_ADDR;
                end else begin
                    rom_rs   = 1'b1;
                    rom_byte = has_winner ? line2_char : score_pkg::CH_SPACE;
                end
            end
            score_pkg::STEP_HOME_HOLD:  rom_byte = score_pkg::CMD_HOME;
            score_pkg::STEP_CLEAR:      rom_byte = score_pkg::CMD_CLEAR;
            default: begin
                rom_rs   = 1'b1;
                rom_byte = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: lcd_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_sequencer #(
    parameter int POWER_WAIT = 70,
    parameter int CMD_WAIT   = 30,
    parameter int LINE_LEN   = 20,
    parameter int HOLD_WAIT  = 400,
    parameter int CLEAR_WAIT = 200
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rom_rs,
    input  logic [score_pkg::LCD_DATA_W-1:0]    rom_byte,
    output score_pkg::lcd_step_e                step,
    output logic [7:0]                          pos,
    output logic                                lcd_e,
    output logic                                lcd_rs,
    output logic                                lcd_rw,
    output logic [score_pkg::LCD_DATA_W-1:0]    lcd_data
);

    localparam int MAX_A    = (POWER_WAIT > CMD_WAIT) ? POWER_WAIT : CMD_WAIT;
    localparam int MAX_B    = (LINE_LEN > HOLD_WAIT) ? LINE_LEN : HOLD_WAIT;
    localparam int MAX_C    = (MAX_A > MAX_B) ? MAX_A : MAX_B;
    localparam int MAX_WAIT = (MAX_C > CLEAR_WAIT) ? MAX_C : CLEAR_WAIT;
    localparam int CNT_W    = ($clog2(MAX_WAIT + 1) > 8) ? $clog2(MAX_WAIT + 1) : 8;

    logic [CNT_W-1:0]         cnt;
    logic [CNT_W-1:0]         limit;
    score_pkg::lcd_step_e     next_step;

    always_comb begin
        case (step)
            score_pkg::STEP_POWER_WAIT: limit = CNT_W'(POWER_WAIT);
            score_pkg::STEP_FUNC_SET,
            score_pkg::STEP_ENTRY_MODE,
            score_pkg::STEP_DISP_ON:    limit = CNT_W'(CMD_WAIT);
            score_pkg::STEP_LINE1,
            score_pkg::STEP_LINE2:      limit = CNT_W'(LINE_LEN);
            score_pkg::STEP_HOME_HOLD:  limit = CNT_W'(HOLD_WAIT);
            score_pkg::STEP_CLEAR:      limit = CNT_W'(CLEAR_WAIT);
            default:                    limit = CNT_W'(POWER_WAIT);
        endcase
    end

    always_comb begin
        case (step)
            score_pkg::STEP_POWER_WAIT: next_step = score_pkg::STEP_FUNC_SET;
            score_pkg::STEP_FUNC_SET:   next_step = score_pkg::STEP_ENTRY_MODE;
            score_pkg::STEP_ENTRY_MODE: next_step = score_pkg::STEP_DISP_ON;
            score_pkg::STEP_DISP_ON:    next_step = score_pkg::STEP_LINE1;
            score_pkg::STEP_LINE1:      next_step = score_pkg::STEP_LINE2;
            score_pkg::STEP_LINE2:      next_step = score_pkg::STEP_HOME_HOLD;
            score_pkg::STEP_HOME_HOLD:  next_step = score_pkg::STEP_CLEAR;
            score_pkg::STEP_CLEAR:      next_step = score_pkg::STEP_LINE1; // Loop forever
            default:                    next_step = score_pkg::STEP_POWER_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            step <= score_pkg::STEP_POWER_WAIT;
            cnt  <= '0;
        end else if (cnt == limit) begin
            step <= next_step;
            cnt  <= '0;
        end else begin
            cnt  <= cnt + CNT_W'(1);
        end
    end

    assign pos = cnt[7:0]; // Only line steps use it

    // One cycle from step/pos to the bus
    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b1;
            lcd_rw   <= 1'b1;
            lcd_data <= '0;
        end else begin
            lcd_e    <= (step != score_pkg::STEP_POWER_WAIT);
            lcd_rw   <= (step == score_pkg::STEP_POWER_WAIT);
            lcd_rs   <= rom_rs;
            lcd_data <= rom_byte;
        end
    end

endmodule

`default_nettype wire

// File: seg_scanner.sv
`timescale 1ns/1ns
`default_nettype none

module seg_scanner (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [score_pkg::DIGIT_W-1:0]     p1_value,
    input  logic [score_pkg::DIGIT_W-1:0]     p2_value,
    output logic [score_pkg::SEG_W-1:0]       seg_data,
    output logic [score_pkg::SCAN_POS-1:0]    seg_pos
);

    localparam int POS_W = $clog2(score_pkg::SCAN_POS);

    logic [POS_W-1:0]               scan_cnt;
    logic [score_pkg::SEG_W-1:0]    p1_seg;
    logic [score_pkg::SEG_W-1:0]    p2_seg;

    assign p1_seg = score_pkg::SEG_DIGIT[p1_value]; // Out of range shows blank
    assign p2_seg = score_pkg::SEG_DIGIT[p2_value];

    always_ff @(posedge clk) begin
        if (!rst) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + POS_W'(1); // Wraps after the last digit
        end
    end

    always_comb begin
        if (!rst) begin
            seg_pos  = '0;
            seg_data = '0;
        end else begin
            seg_pos = ~(score_pkg::SCAN_POS'(1) << scan_cnt); // One low select
            if (scan_cnt == '0) begin
                seg_data = p1_seg;
            end else if (scan_cnt == POS_W'(score_pkg::SCAN_POS - 1)) begin
                seg_data = p2_seg;
            end else begin
                seg_data = score_pkg::SEG_FILL;
            end
        end
    end

endmodule

`default_nettype wire

// File: score_display_top.sv
`timescale 1ns/1ns
`default_nettype none

module score_display_top #(
    parameter int POWER_WAIT = 70,
    parameter int CMD_WAIT   = 30,
    parameter int LINE_LEN   = 20,
    parameter int HOLD_WAIT  = 400,
    parameter int CLEAR_WAIT = 200
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [1:0]                          winner,
    input  logic [score_pkg::DIGIT_W-1:0]       p1_value,
    input  logic [score_pkg::DIGIT_W-1:0]       p2_value,
    output logic                                lcd_e,
    output logic                                lcd_rs,
    output logic                                lcd_rw,
    output logic [score_pkg::LCD_DATA_W-1:0]    lcd_data,
    output logic [score_pkg::SEG_W-1:0]         seg_data,
    output logic [score_pkg::SCAN_POS-1:0]      seg_pos
);

    score_pkg::lcd_step_e                 step;
    logic [7:0]                           pos;
    logic                                 rom_rs;
    logic [score_pkg::LCD_DATA_W-1:0]     rom_byte;

    lcd_sequencer #(
        .POWER_WAIT (POWER_WAIT),
        .CMD_WAIT   (CMD_WAIT),
        .LINE_LEN   (LINE_LEN),
        .HOLD_WAIT  (HOLD_WAIT),
        .CLEAR_WAIT (CLEAR_WAIT)
    ) u_lcd_sequencer (
        .clk      (clk),
        .rst      (rst),
        .rom_rs   (rom_rs),
        .rom_byte (rom_byte),
        .step     (step),
        .pos      (pos),
        .lcd_e    (lcd_e),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_data (lcd_data)
    );

    lcd_text_rom u_lcd_text_rom (
        .step     (step),
        .pos      (pos),
        .winner   (winner),
        .rom_rs   (rom_rs),
        .rom_byte (rom_byte)
    );

    seg_scanner u_seg_scanner (
        .clk      (clk),
        .rst      (rst),
        .p1_value (p1_value),
        .p2_value (p2_value),
        .seg_data (seg_data),
        .seg_pos  (seg_pos)
    );

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk); // Released on a falling edge
        rst = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
    parameter int POWER_WAIT = 7,
    parameter int CMD_WAIT   = 3,
    parameter int LINE_LEN   = 20,
    parameter int HOLD_WAIT  = 40,
    parameter int CLEAR_WAIT = 20,
    parameter int GOLD_DEPTH = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  winner,
    input  logic [2:0]  p1_value,
    input  logic [2:0]  p2_value,
    input  logic        lcd_e,
    input  logic        lcd_rs,
    input  logic        lcd_rw,
    input  logic [7:0]  lcd_data,
    input  logic [6:0]  seg_data,
    input  logic [7:0]  seg_pos,
    input  logic [7:0]  golden [0:GOLD_DEPTH-1],
    output int          error_count,
    output int          lines_done
);

    localparam int LINE_BYTES  = LINE_LEN + 1;
    localparam int PHASE_WORDS = 1 + 2 * LINE_BYTES;
    localparam int LIMIT [0:7] = '{POWER_WAIT, CMD_WAIT, CMD_WAIT, CMD_WAIT,
                                   LINE_LEN, LINE_LEN, HOLD_WAIT, CLEAR_WAIT};
    localparam logic [7:0] CMD_BYTE [0:7] = '{8'h00, 8'h3C, 8'h06, 8'h0C,
                                              8'h80, 8'hC0, 8'h02, 8'h01};

    int          errors = 0;
    int          lines = 0;
    int          rst_edges = 0;
    int          m_step = 0; // Reference step and count
    int          m_cnt = 0;
    int          seg_idx = 0;
    bit          have_prev = 1'b0;
    int          prev_step = 0;
    int          prev_cnt = 0;
    logic [1:0]  prev_winner = 2'd0;
    bit          prev_clean = 1'b0;
    logic [1:0]  line_winner = 2'd0;
    bit          line_clean = 1'b0;

    assign error_count = errors;
    assign lines_done  = lines;

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    function automatic int phase_of(input logic [1:0] w);
        int idx;
        idx = -1;
        for (int i = 0; i < int'(golden[9]); i++) begin
            if (idx < 0 && golden[10 + i * PHASE_WORDS] == {6'd0, w}) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Bus now shows what the previous edge looked up
    task automatic check_bus();
        logic [10:0] want;
        int          ph;
        bit          skip;
        skip = 1'b0;
        want = {3'b100, CMD_BYTE[prev_step]};
        if (prev_step == 0) begin
            want = 11'b011_0000_0000; // Idle during power wait
        end else if ((prev_step == 4 || prev_step == 5) && prev_cnt != 0) begin
            ph = phase_of(prev_winner);
            if (ph < 0) begin
                errors++;
                $display("Golden file has no phase for winner code %0d", prev_winner);
                skip = 1'b1;
            end else if (!prev_clean) begin
                skip = 1'b1;
            end else begin
                want = {3'b110, golden[11 + ph * PHASE_WORDS + (prev_step - 4) * LINE_BYTES
                                       + prev_cnt]};
                if (prev_cnt == LINE_LEN) lines++;
            end
        end
        if (!skip && {lcd_e, lcd_rs, lcd_rw, lcd_data} !== want) begin
            report_error($sformatf("LCD bus %b/%b/%b/%h, want %b/%b/%b/%h (step %0d pos %0d)",
                lcd_e, lcd_rs, lcd_rw, lcd_data, want[10], want[9], want[8], want[7:0],
                prev_step, prev_cnt));
        end
    endtask

    task automatic check_seg();
        logic [6:0] pat;
        logic [7:0] sel;
        pat = golden[8][6:0];
        if (seg_idx == 0) pat = golden[p1_value][6:0];
        if (seg_idx == 7) pat = golden[p2_value][6:0];
        for (int i = 0; i < 8; i++) begin
            sel[i] = (i != seg_idx); // Only the scanned digit is low
        end
        if ({seg_pos, seg_data} !== {sel, pat}) begin
            report_error($sformatf("seg_pos %b seg_data %b at digit %0d (p1 %0d p2 %0d)",
                seg_pos, seg_data, seg_idx, p1_value, p2_value));
        end
    endtask

    task automatic advance_model();
        prev_step   = m_step;
        prev_cnt    = m_cnt;
        prev_winner = winner;
        if (m_step == 4 || m_step == 5) begin
            if (m_cnt == 0) begin
                line_winner = winner;
                line_clean  = 1'b1;
            end else if (winner !== line_winner) begin
                line_clean = 1'b0; // Winner moved mid-line
            end
        end
        prev_clean = line_clean;
        have_prev  = 1'b1;
        if (m_cnt == LIMIT[m_step]) begin
            m_cnt  = 0;
            m_step = (m_step == 7) ? 4 : m_step + 1;
        end else begin
            m_cnt++;
        end
        seg_idx = (seg_idx + 1) % 8;
    endtask

    // Sampled before the edge takes effect
    always @(posedge clk) begin
        if (!rst) begin
            if (rst_edges > 0 && {lcd_e, lcd_rs, lcd_rw, lcd_data} !== 11'b011_0000_0000) begin
                report_error($sformatf("LCD bus %b/%b/%b/%h not idle in reset",
                    lcd_e, lcd_rs, lcd_rw, lcd_data));
            end
            if ({seg_pos, seg_data} !== 15'd0) begin
                report_error($sformatf("seg_pos %b seg_data %b not zero in reset",
                    seg_pos, seg_data));
            end
            rst_edges++;
            m_step    = 0;
            m_cnt     = 0;
            seg_idx   = 0;
            have_prev = 1'b0;
        end else begin
            if (have_prev) check_bus();
            check_seg();
            advance_model();
        end
    end

endmodule

`default_nettype wire

// File: tb_score_display.sv
`timescale 1ns/1ns
`default_nettype none

module tb_score_display;

    localparam int POWER_WAIT   = 7;
    localparam int CMD_WAIT     = 3;
    localparam int LINE_LEN     = 20;
    localparam int HOLD_WAIT    = 40;
    localparam int CLEAR_WAIT   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int GOLD_DEPTH   = 256;
    localparam int MAX_PHASES   = 5;
    localparam int PHASE_WORDS  = 1 + 2 * (LINE_LEN + 1);
    localparam int SETUP_LEN    = POWER_WAIT + 1 + 3 * (CMD_WAIT + 1);
    localparam int LOOP_LEN     = 2 * (LINE_LEN + 1) + HOLD_WAIT + 1 + CLEAR_WAIT + 1;
    localparam int PHASE_LEN    = 2 * LOOP_LEN + LOOP_LEN / 3; // Changes land mid-loop

    logic        clk;
    logic        rst;
    logic [1:0]  winner;
    logic [2:0]  p1_value;
    logic [2:0]  p2_value;
    logic        lcd_e;
    logic        lcd_rs;
    logic        lcd_rw;
    logic [7:0]  lcd_data;
    logic [6:0]  seg_data;
    logic [7:0]  seg_pos;
    logic [7:0]  golden [0:GOLD_DEPTH-1];
    logic [31:0] lcg_state = 32'h3c1c;
    int          cycles = 0;
    int          timeout_limit = 0;
    int          n_phases;
    int          error_count;
    int          lines_done;

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    score_display_top #(
        .POWER_WAIT (POWER_WAIT),
        .CMD_WAIT   (CMD_WAIT),
        .LINE_LEN   (LINE_LEN),
        .HOLD_WAIT  (HOLD_WAIT),
        .CLEAR_WAIT (CLEAR_WAIT)
    ) u_score_display_top (
        .clk(clk), .rst(rst), .winner(winner), .p1_value(p1_value), .p2_value(p2_value),
        .lcd_e(lcd_e), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_data(lcd_data),
        .seg_data(seg_data), .seg_pos(seg_pos)
    );

    tb_checker #(
        .POWER_WAIT(POWER_WAIT), .CMD_WAIT(CMD_WAIT), .LINE_LEN(LINE_LEN),
        .HOLD_WAIT(HOLD_WAIT), .CLEAR_WAIT(CLEAR_WAIT), .GOLD_DEPTH(GOLD_DEPTH)
    ) u_tb_checker (
        .clk(clk), .rst(rst), .winner(winner), .p1_value(p1_value), .p2_value(p2_value),
        .lcd_e(lcd_e), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_data(lcd_data),
        .seg_data(seg_data), .seg_pos(seg_pos), .golden(golden),
        .error_count(error_count), .lines_done(lines_done)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Fresh player values each falling edge, 0 to 7
    task automatic run_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            lcg_state = lcg_next(lcg_state);
            p1_value  = lcg_state[18:16];
            lcg_state = lcg_next(lcg_state);
            p2_value  = lcg_state[18:16];
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (timeout_limit != 0 && cycles >= timeout_limit) begin
            $display("Timeout: the run did not end within %0d clock cycles", timeout_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        winner   = 2'd0;
        p1_value = 3'd0;
        p2_value = 3'd0;
        $readmemh("score_display_golden.txt", golden);
        n_phases = int'(golden[9]);
        if (n_phases < 1 || n_phases > MAX_PHASES) begin
            $display("Golden file is missing or holds a bad phase count (%0d)", n_phases);
            $display("Checks failed");
            $finish;
        end else begin
            timeout_limit = RESET_CYCLES + SETUP_LEN + n_phases * PHASE_LEN + 2 * LOOP_LEN;
            wait (rst === 1'b1);
            for (int ph = 0; ph < n_phases; ph++) begin
                @(negedge clk);
                winner = golden[10 + ph * PHASE_WORDS][1:0];
                run_cycles(PHASE_LEN);
            end
            @(posedge clk);
            #1;
            if (lines_done < 2 * n_phases) begin
                $display("Too few whole LCD lines were compared");
            end
            $display("Closing: %0d errors, %0d whole lines compared", error_count, lines_done);
            if (error_count == 0 && lines_done >= 2 * n_phases) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: score_display_golden.txt
// Words 0-7: segments for player values 0-7, word 8: middle fill, word 9: phase count
// Each phase: winner code, then line 1 and line 2 bytes for pos 0 to 20 (address first)
7F 4F 12 06 4C 24 7F 7F
01
04
// Player 1 wins
01
80 20 50 31 20 51 69 6E 20 20 20 20 20 20 20 20 20 20 20 20 20
C0 20 9D 9D 9D 20 9D 9D 9D 20 20 20 20 20 20 20 20 20 20 20 20
// Player 2 wins
02
80 20 50 32 20 51 69 6E 20 20 20 20 20 20 20 20 20 20 20 20 20
C0 20 9D 9D 9D 20 9D 9D 9D 20 20 20 20 20 20 20 20 20 20 20 20
// No winner
00
80 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
C0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
// Unused code, shown as no winner
03
80 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
C0 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20

// File: score_display.f
score_pkg.sv
lcd_text_rom.sv
lcd_sequencer.sv
seg_scanner.sv
score_display_top.sv
tb_clock.sv
tb_checker.sv
tb_score_display.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f score_display.f --top-module tb_score_display -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep "All checks passed" > /dev/null \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
